// ==== include/wiring_params.svh ====
`ifndef WIRING_PARAMS_SVH
`define WIRING_PARAMS_SVH

// number of indicator lights per machine
`define MAX_WIRING_WIDTH 10

// button units in the chain, also the widest subset mask
`define MAX_BUTTON_WIRINGS 8

// input buffer entries, equal to the sender's starting credit
`define WIRING_FIFO_DEPTH 4

`endif

// ==== hdl/wiring_pkg.sv ====
`include "wiring_params.svh"

package wiring_pkg;

    typedef logic [`MAX_WIRING_WIDTH-1:0] wiring_t;
    typedef logic [`MAX_BUTTON_WIRINGS-1:0] button_mask_t;
    typedef logic [3:0] press_count_t; // up to 8 presses

    typedef struct packed {
        logic is_light; // light pattern beat
        logic last;     // final beat of a machine
        wiring_t data;
    } wiring_beat_t;

    typedef struct packed {
        logic found;
        press_count_t presses;
        button_mask_t buttons;
    } solve_result_t;

    typedef enum logic [2:0] {
        capture_light,
        capture_buttons,
        update_combinations,
        run_solver,
        report
    } solver_state_e;

endpackage

// ==== hdl/wiring_beat_fifo.sv ====
`timescale 1ns/100ps
`include "wiring_params.svh"

module wiring_beat_fifo (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     push_valid,
    input  wiring_pkg::wiring_beat_t push_beat,
    input  logic                     pop_ready,
    output logic                     pop_valid,
    output wiring_pkg::wiring_beat_t pop_beat,
    output logic                     credit_return
);

    localparam int depth = `WIRING_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);

    wiring_pkg::wiring_beat_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             pop;

    // no full check, the sender never pushes without a credit
    assign pop       = pop_valid && pop_ready;
    assign pop_valid = (count != '0);
    assign pop_beat  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop; // one credit back per popped beat
            if (push_valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/button_wiring.sv ====
`timescale 1ns/100ps

module button_wiring (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                clear,
    input  logic                wiring_valid_in,
    input  wiring_pkg::wiring_t wiring_data_in,
    input  logic                enable,
    output logic                wiring_valid_out,
    output wiring_pkg::wiring_t wiring_data_out,
    output wiring_pkg::wiring_t wiring
);

    logic                loaded;
    wiring_pkg::wiring_t wiring_q;
    logic                capture;

    assign capture = wiring_valid_in && !loaded;

    // a loaded unit passes everything further down
    assign wiring_valid_out = wiring_valid_in && loaded;
    assign wiring_data_out  = wiring_data_in;

    assign wiring = enable ? wiring_q : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            loaded <= 1'b0;
        end else if (clear) begin
            loaded <= 1'b0;
        end else if (capture) begin
            loaded <= 1'b1;
        end
    end

    // unused units stay at zero so they never change the xor
    always_ff @(posedge clk) begin
        if (clear) begin
            wiring_q <= '0;
        end else if (capture) begin
            wiring_q <= wiring_data_in;
        end
    end

endmodule

// ==== hdl/gospers_hack_counter.sv ====
`timescale 1ns/100ps
`include "wiring_params.svh"

module gospers_hack_counter (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic                     advance,
    output wiring_pkg::button_mask_t bits,
    output logic                     last
);

    localparam int width = `MAX_BUTTON_WIRINGS;

    wiring_pkg::button_mask_t low_bit;
    wiring_pkg::button_mask_t ripple;
    wiring_pkg::button_mask_t fill_mask;
    wiring_pkg::button_mask_t next_bits;
    logic [width:0]           sum;
    int                       ones;
    int                       tz;

    always_comb begin
        low_bit = bits & (~bits + 1'b1); // lowest set bit
        sum     = {1'b0, bits} + {1'b0, low_bit};
        ripple  = sum[width-1:0];

        tz   = 0;
        ones = 0;
        for (int i = width - 1; i >= 0; i--) begin
            if (bits[i]) begin
                tz = i; // ends on the lowest set index
            end
            ones += int'(bits[i]);
        end

        // smallest mask of the next popcount
        fill_mask = '0;
        for (int i = 0; i < width; i++) begin
            if (i <= ones) begin
                fill_mask[i] = 1'b1;
            end
        end

        // carry out means the largest mask of this popcount was reached
        if (sum[width] || bits == '0) begin
            next_bits = fill_mask;
        end else begin
            next_bits = ripple | (((ripple ^ bits) >> 2) >> tz);
        end
    end

    assign last = (bits == '1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bits <= '0;
        end else if (start) begin
            bits <= '0; // empty subset first
        end else if (advance) begin
            bits <= next_bits;
        end
    end

endmodule

// ==== hdl/machine_wiring_solver.sv ====
`timescale 1ns/100ps
`include "wiring_params.svh"

module machine_wiring_solver (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      beat_valid,
    input  wiring_pkg::wiring_beat_t  beat,
    output logic                      solver_ready,
    output logic                      result_valid,
    output wiring_pkg::solve_result_t result
);

    localparam int buttons = `MAX_BUTTON_WIRINGS;

    wiring_pkg::solver_state_e state;
    wiring_pkg::solver_state_e next_state;

    wiring_pkg::wiring_t       light_q;
    wiring_pkg::wiring_t       lights_now;
    wiring_pkg::button_mask_t  subset;
    wiring_pkg::press_count_t  presses_now;
    wiring_pkg::solve_result_t result_q;

    logic clear_units;
    logic start_enum;
    logic advance_enum;
    logic subset_last;
    logic match;
    logic searching;

    // chain has one extra node past the last unit
    logic                chain_valid [buttons+1];
    wiring_pkg::wiring_t chain_data  [buttons+1];
    wiring_pkg::wiring_t unit_wiring [buttons];

    assign solver_ready = (state == wiring_pkg::capture_light)
                       || (state == wiring_pkg::capture_buttons);
    assign clear_units  = (state == wiring_pkg::capture_light);
    assign start_enum   = (state == wiring_pkg::update_combinations);
    assign searching    = (state == wiring_pkg::run_solver);
    assign result_valid = (state == wiring_pkg::report);

    assign chain_valid[0] = beat_valid && (state == wiring_pkg::capture_buttons);
    assign chain_data[0]  = beat.data;

    gospers_hack_counter u_counter (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start_enum),
        .advance (advance_enum),
        .bits    (subset),
        .last    (subset_last)
    );

    for (genvar i = 0; i < buttons; i++) begin : g_button
        button_wiring u_button (
            .clk              (clk),
            .arst_n           (arst_n),
            .clear            (clear_units),
            .wiring_valid_in  (chain_valid[i]),
            .wiring_data_in   (chain_data[i]),
            .enable           (subset[i]),
            .wiring_valid_out (chain_valid[i+1]),
            .wiring_data_out  (chain_data[i+1]),
            .wiring           (unit_wiring[i])
        );
    end

    always_comb begin
        lights_now  = '0;
        presses_now = '0;
        for (int j = 0; j < buttons; j++) begin
            lights_now  = lights_now ^ unit_wiring[j];
            presses_now = presses_now + wiring_pkg::press_count_t'(subset[j]);
        end
    end

    assign match        = searching && (lights_now == light_q);
    assign advance_enum = searching && !match && !subset_last;

    always_comb begin
        next_state = state;
        case (state)
            wiring_pkg::capture_light: begin
                // stray button beats are dropped here
                if (beat_valid && beat.is_light) begin
                    next_state = beat.last ? wiring_pkg::update_combinations
                                           : wiring_pkg::capture_buttons;
                end
            end
            wiring_pkg::capture_buttons: begin
                if (beat_valid && beat.last) begin
                    next_state = wiring_pkg::update_combinations;
                end
            end
            wiring_pkg::update_combinations: begin
                next_state = wiring_pkg::run_solver;
            end
            wiring_pkg::run_solver: begin
                if (match || subset_last) begin
                    next_state = wiring_pkg::report;
                end
            end
            wiring_pkg::report: begin
                next_state = wiring_pkg::capture_light;
            end
            default: begin
                next_state = wiring_pkg::capture_light;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= wiring_pkg::capture_light;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (clear_units && beat_valid && beat.is_light) begin
            light_q <= beat.data;
        end
        if (match) begin
            result_q.found   <= 1'b1;
            result_q.presses <= presses_now;
            result_q.buttons <= subset;
        end else if (searching && subset_last) begin
            result_q <= '0; // every subset failed
        end
    end

    assign result = result_q;

endmodule

// ==== hdl/machine_solver_top.sv ====
`timescale 1ns/100ps

module machine_solver_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      beat_valid,
    input  wiring_pkg::wiring_beat_t  beat,
    output logic                      credit_return,
    output logic                      result_valid,
    output wiring_pkg::solve_result_t result
);

    logic                     fifo_valid;
    wiring_pkg::wiring_beat_t fifo_beat;
    logic                     solver_ready;

    // buffers beats while the solver searches
    wiring_beat_fifo u_fifo (
        .clk           (clk),
        .arst_n        (arst_n),
        .push_valid    (beat_valid),
        .push_beat     (beat),
        .pop_ready     (solver_ready),
        .pop_valid     (fifo_valid),
        .pop_beat      (fifo_beat),
        .credit_return (credit_return)
    );

    machine_wiring_solver u_solver (
        .clk          (clk),
        .arst_n       (arst_n),
        .beat_valid   (fifo_valid),
        .beat         (fifo_beat),
        .solver_ready (solver_ready),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk
);

    localparam real half_period = 2.0; // 4 ns period

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

// ==== dv/machine_solver_tb.sv ====
`timescale 1ns/100ps
`include "wiring_params.svh"

module machine_solver_tb;

    localparam int machine_count = 40;
    localparam int seed          = 32'hb50e;
    localparam int margin        = 16;
    localparam int buttons       = `MAX_BUTTON_WIRINGS;
    localparam int depth         = `WIRING_FIFO_DEPTH;
    localparam int timeout_limit =
        machine_count * ((1 << buttons) + 2 * (buttons + 1) + margin);

    logic                      clk;
    logic                      arst_n;
    logic                      beat_valid;
    wiring_pkg::wiring_beat_t  beat;
    logic                      credit_return;
    logic                      result_valid;
    wiring_pkg::solve_result_t result;

    wiring_pkg::solve_result_t expected_q [$];
    wiring_pkg::wiring_t       cur_wiring [buttons];
    wiring_pkg::wiring_t       cur_light;
    int                        cur_buttons;

    int credits      = depth;
    int beats_sent   = 0;
    int credits_back = 0;
    int results_seen = 0;
    int cycles       = 0;
    int value_errors  = 0;
    int credit_errors = 0;
    int other_errors  = 0;

    tb_clock_gen clk_gen_i (
        .clk (clk)
    );

    machine_solver_top dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .beat_valid    (beat_valid),
        .beat          (beat),
        .credit_return (credit_return),
        .result_valid  (result_valid),
        .result        (result)
    );

    task automatic check_result(input wiring_pkg::solve_result_t got,
                                input wiring_pkg::solve_result_t exp);
        if (got !== exp) begin
            $display("[ERROR] result got 0x%h (found %h presses %h buttons %h) expected 0x%h",
                     got, got.found, got.presses, got.buttons, exp);
            value_errors++;
        end
    endtask

    task automatic check_credit(input int held);
        if (held < 0 || held > depth) begin
            $display("sender credit count left its range: holds %0d, allowed 0 to %0d",
                     held, depth);
            credit_errors++;
        end
    endtask

    // minimal subset: popcount 0 upward, then ascending value
    function automatic wiring_pkg::solve_result_t model_result();
        wiring_pkg::solve_result_t r;
        wiring_pkg::wiring_t       acc;
        int                        ones;
        r = '0;
        for (int k = 0; k <= buttons; k++) begin
            for (int v = 0; v < (1 << buttons); v++) begin
                ones = 0;
                acc  = '0;
                for (int b = 0; b < buttons; b++) begin
                    if (v[b]) begin
                        ones++;
                        acc = acc ^ cur_wiring[b];
                    end
                end
                if (ones == k && acc == cur_light) begin
                    r.found   = 1'b1;
                    r.presses = wiring_pkg::press_count_t'(k);
                    r.buttons = wiring_pkg::button_mask_t'(v);
                    return r;
                end
            end
        end
        return r;
    endfunction

    task automatic build_machine(input int idx);
        int                       kind;
        wiring_pkg::button_mask_t pick;
        kind        = $urandom_range(0, 7);
        cur_buttons = $urandom_range(0, buttons);
        if (idx == 1 || kind == 1) begin
            cur_buttons = 0;
        end
        for (int b = 0; b < buttons; b++) begin
            cur_wiring[b] = '0;
            if (b < cur_buttons && $urandom_range(0, 5) != 0) begin
                cur_wiring[b] = wiring_pkg::wiring_t'($urandom);
            end
        end
        pick = wiring_pkg::button_mask_t'($urandom);
        if (idx == 0 || kind == 0) begin
            cur_light = '0;
        end else if (idx == 1 || kind == 1) begin
            cur_light = wiring_pkg::wiring_t'($urandom) | 1'b1; // never solvable
        end else if (kind < 4) begin
            cur_light = wiring_pkg::wiring_t'($urandom);
        end else begin
            cur_light = '0; // xor of a random subset, so solvable
            for (int b = 0; b < buttons; b++) begin
                if (pick[b]) begin
                    cur_light = cur_light ^ cur_wiring[b];
                end
            end
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send_beat(input logic is_light, input logic last,
                             input wiring_pkg::wiring_t data);
        while (credits == 0 || $urandom_range(0, 3) == 0) begin
            beat_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        beat_valid    = 1'b1;
        beat.is_light = is_light;
        beat.last     = last;
        beat.data     = data;
        credits--;
        beats_sent++;
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    always @(negedge clk) begin
        if (arst_n) begin
            if (credit_return) begin
                credits++;
                credits_back++;
                check_credit(credits);
            end
            if (result_valid) begin
                if (expected_q.size() == 0) begin
                    $display("result appeared with no machine waiting for one");
                    other_errors++;
                end else begin
                    check_result(result, expected_q.pop_front());
                end
                results_seen++;
            end
        end
    end

    // driver
    initial begin
        void'($urandom(seed));
        beat_valid = 1'b0;
        beat       = '0;
        wait (arst_n === 1'b1);
        @(posedge clk);
        #1;
        for (int m = 0; m < machine_count; m++) begin
            build_machine(m);
            expected_q.push_back(model_result());
            send_beat(1'b1, cur_buttons == 0, cur_light);
            for (int b = 0; b < cur_buttons; b++) begin
                send_beat(1'b0, b == cur_buttons - 1, cur_wiring[b]);
            end
        end
        beat_valid = 1'b0;
    end

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        while (results_seen < machine_count && cycles < timeout_limit) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        if (results_seen < machine_count) begin
            $display("timeout after %0d cycles with %0d of %0d results", cycles,
                     results_seen, machine_count);
            other_errors++;
        end
        if (results_seen > machine_count) begin
            $display("more results than machines: %0d", results_seen);
            other_errors++;
        end
        if (credits != depth || credits_back != beats_sent) begin
            $display("not every beat was credited back: sent %0d, returned %0d, holding %0d",
                     beats_sent, credits_back, credits);
            credit_errors++;
        end

        $display("value errors %0d, credit errors %0d, other errors %0d, results %0d of %0d",
                 value_errors, credit_errors, other_errors, results_seen, machine_count);
        if (value_errors + credit_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
hdl/wiring_pkg.sv
hdl/wiring_beat_fifo.sv
hdl/button_wiring.sv
hdl/gospers_hack_counter.sv
hdl/machine_wiring_solver.sv
hdl/machine_solver_top.sv
dv/tb_clock_gen.sv
dv/machine_solver_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the machine solver testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary -f sim.f --top-module machine_solver_tb -o machine_solver_sim \
    > build.log 2>&1 \
    && ./obj_dir/machine_solver_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log \
    && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation finished without failure"; exit 0; }
